// File: rob_cfg_pkg.sv
// machine widths, program counter type and index and count sizing helpers
package rob_cfg_pkg;

    localparam int PC_W    = 32;  // program counter width
    localparam int CAUSE_W = 5;   // exception cause code width

    typedef logic [PC_W-1:0] pc_t;

    // bits needed to address a ring of depth entries
    function automatic int idx_bits(input int depth);
        if (depth > 1) begin
            return $clog2(depth);
        end
        return 1;
    endfunction

    // bits needed to hold any count from zero to depth
    function automatic int cnt_bits(input int depth);
        return $clog2(depth + 1);
    endfunction

endpackage

// File: rob_result_pkg.sv
// execute result word encoding, exception cause codes and the result word union
package rob_result_pkg;

    import rob_cfg_pkg::*;

    localparam int INFO_W = 40;  // result word width, byte aligned

    typedef enum logic [CAUSE_W-1:0] {
        CAUSE_ILLEGAL_INSTR   = CAUSE_W'(2),
        CAUSE_LOAD_MISALIGN   = CAUSE_W'(4),
        CAUSE_LOAD_PAGE_FAULT = CAUSE_W'(13)
    } cause_t;

    typedef struct packed {
        logic [INFO_W-CAUSE_W-PC_W-1:0] pad;
        cause_t                         cause;
        pc_t                            tval;   // faulting address or instruction bits
    } exc_info_t;

    typedef struct packed {
        logic [INFO_W-PC_W-1:0] pad;
        pc_t                    target;  // resolved next pc
    } br_info_t;

    // one result word, read by the flag that comes with it
    typedef union packed {
        br_info_t  br;   // valid when the mispredict flag is set
        exc_info_t exc;  // valid when the exception flag is set
    } exe_info_u;

endpackage

// File: rob_entry_table.sv
// reorder buffer entry ring with allocation, completion, in-order commit, flush and credits
`timescale 1ns/1ps

module rob_entry_table
    import rob_cfg_pkg::*, rob_result_pkg::*;
#(
    parameter int  DEPTH = 16,
    parameter int  DEC_W = 2,
    parameter int  COM_W = 2,
    parameter int  EXE_W = 2,
    localparam int IDX_W = idx_bits(DEPTH),
    localparam int CNT_W = cnt_bits(DEPTH)
)(
    input  logic                             clk,
    input  logic                             rst,
    input  logic      [DEC_W-1:0]            dec_valid,
    input  pc_t       [DEC_W-1:0]            dec_pc,
    input  logic      [EXE_W-1:0]            exe_valid,
    input  logic      [EXE_W-1:0][IDX_W-1:0] exe_tag,
    input  logic      [EXE_W-1:0]            exe_exc,
    input  exe_info_u [EXE_W-1:0]            exe_info,
    input  logic                             flush_valid,
    input  logic                             flush_keep_valid,
    input  logic      [IDX_W-1:0]            flush_keep_tag,
    output logic      [IDX_W-1:0]            alloc_tag,
    output logic      [IDX_W-1:0]            head_tag,
    output logic      [CNT_W-1:0]            occupancy,
    output logic                             head_exc,
    output pc_t                              head_pc,
    output exc_info_t                        head_info,
    output logic      [COM_W-1:0]            commit_valid,
    output pc_t       [COM_W-1:0]            commit_pc,
    output logic      [CNT_W-1:0]            credit_ret
);

    logic [IDX_W-1:0] head;       // oldest entry
    logic [IDX_W-1:0] tail;       // next free entry
    logic [CNT_W-1:0] count;      // entries in flight

    pc_t              pc_mem   [DEPTH];
    exc_info_t        info_mem [DEPTH];
    logic [DEPTH-1:0] done;       // result written back
    logic [DEPTH-1:0] exc;        // result carries an exception

    logic [CNT_W-1:0] n_dec;      // valid decode slots this cycle
    logic [CNT_W-1:0] n_commit;   // entries retiring this cycle
    logic [CNT_W-1:0] n_flush;    // entries discarded this cycle
    logic [IDX_W-1:0] keep_dist;  // distance of the last kept entry from head

    assign alloc_tag = tail;
    assign head_tag  = head;
    assign occupancy = count;
    assign head_pc   = pc_mem[head];
    assign head_info = info_mem[head];
    assign head_exc  = (count != '0) && done[head] && exc[head];
    assign keep_dist = flush_keep_tag - head;

    always_comb begin
        n_dec = '0;
        for (int i = 0; i < DEC_W; i++) begin
            if (dec_valid[i]) begin
                n_dec = n_dec + CNT_W'(1);
            end
        end
    end

    // committable prefix from head, stops at the first blocker
    always_comb begin
        logic [IDX_W-1:0] idx;
        logic             ok;
        ok       = 1'b1;
        n_commit = '0;
        for (int i = 0; i < COM_W; i++) begin
            idx = head + IDX_W'(i);
            ok  = ok && (CNT_W'(i) < count) && done[idx] && !exc[idx];
            if (flush_valid && !(flush_keep_valid && IDX_W'(i) <= keep_dist)) begin
                ok = 1'b0;  // younger than the redirecting branch
            end
            commit_valid[i] = ok;
            commit_pc[i]    = ok ? pc_mem[idx] : '0;
            if (ok) begin
                n_commit = n_commit + CNT_W'(1);
            end
        end
    end

    always_comb begin
        n_flush = '0;
        if (flush_valid) begin
            if (flush_keep_valid) begin
                n_flush = count - CNT_W'(keep_dist) - CNT_W'(1);  // all past the kept branch
            end else begin
                n_flush = count;                                 // trap drops everything
            end
        end
    end

    // decode offered during a flush is wrong-path and goes straight back as credit
    assign credit_ret = n_commit + n_flush + (flush_valid ? n_dec : '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
            exc   <= '0;
        end else begin
            head <= head + IDX_W'(n_commit);
            if (flush_valid) begin
                tail  <= flush_keep_valid ? flush_keep_tag + IDX_W'(1) : head;
                count <= count - n_commit - n_flush;
            end else begin
                tail  <= tail + IDX_W'(n_dec);
                count <= count + n_dec - n_commit;
            end
            for (int i = 0; i < DEC_W; i++) begin
                if (dec_valid[i] && !flush_valid) begin
                    done[tail + IDX_W'(i)] <= 1'b0;  // fresh entry starts incomplete
                    exc[tail + IDX_W'(i)]  <= 1'b0;
                end
            end
            for (int i = 0; i < EXE_W; i++) begin
                if (exe_valid[i]) begin
                    done[exe_tag[i]] <= 1'b1;
                    exc[exe_tag[i]]  <= exe_exc[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEC_W; i++) begin
            if (dec_valid[i] && !flush_valid) begin
                pc_mem[tail + IDX_W'(i)] <= dec_pc[i];
            end
        end
        for (int i = 0; i < EXE_W; i++) begin
            if (exe_valid[i] && exe_exc[i]) begin
                info_mem[exe_tag[i]] <= exe_info[i].exc;  // cause and tval view
            end
        end
    end

endmodule

// File: branch_miss_tracker.sv
// oldest mispredicted branch search over execute results, held for one cycle
`timescale 1ns/1ps

module branch_miss_tracker
    import rob_cfg_pkg::*, rob_result_pkg::*;
#(
    parameter int  DEPTH = 16,
    parameter int  EXE_W = 2,
    localparam int IDX_W = idx_bits(DEPTH),
    localparam int CNT_W = cnt_bits(DEPTH)
)(
    input  logic                             clk,
    input  logic                             rst,
    input  logic      [EXE_W-1:0]            exe_valid,
    input  logic      [EXE_W-1:0][IDX_W-1:0] exe_tag,
    input  logic      [EXE_W-1:0]            exe_misp,
    input  exe_info_u [EXE_W-1:0]            exe_info,
    input  logic      [IDX_W-1:0]            head_tag,
    input  logic      [CNT_W-1:0]            occupancy,
    input  logic                             flush_valid,
    input  logic                             flush_keep_valid,
    input  logic      [IDX_W-1:0]            flush_keep_tag,
    output logic                             miss_valid,
    output logic      [IDX_W-1:0]            miss_tag,
    output pc_t                              miss_target
);

    logic             held_valid;
    logic [IDX_W-1:0] held_tag;
    pc_t              held_target;
    logic [IDX_W-1:0] held_age;

    logic             cand_valid;
    logic [IDX_W-1:0] cand_tag;
    logic [IDX_W-1:0] cand_age;
    pc_t              cand_target;
    logic [IDX_W-1:0] keep_age;   // age of the last entry a flush keeps

    assign keep_age = flush_keep_tag - head_tag;

    // age is the distance from head, smaller is older
    always_comb begin
        logic [IDX_W-1:0] age;
        logic             live;
        cand_valid  = 1'b0;
        cand_tag    = '0;
        cand_age    = '0;
        cand_target = '0;
        for (int i = 0; i < EXE_W; i++) begin
            age  = exe_tag[i] - head_tag;
            live = exe_valid[i] && exe_misp[i] && (CNT_W'(age) < occupancy);
            if (flush_valid && !(flush_keep_valid && age <= keep_age)) begin
                live = 1'b0;  // lost in this cycle's flush
            end
            if (live && (!cand_valid || age < cand_age)) begin
                cand_valid  = 1'b1;
                cand_tag    = exe_tag[i];
                cand_age    = age;
                cand_target = exe_info[i].br.target;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else begin
            held_valid <= cand_valid;  // one cycle only
        end
    end

    always_ff @(posedge clk) begin
        if (cand_valid) begin
            held_tag    <= cand_tag;
            held_target <= cand_target;
        end
    end

    assign held_age    = held_tag - head_tag;
    assign miss_valid  = held_valid && (CNT_W'(held_age) < occupancy);
    assign miss_tag    = held_tag;
    assign miss_target = held_target;

endmodule

// File: redirect_select.sv
// front end redirect selection between head trap and held misprediction, with flush request
`timescale 1ns/1ps

module redirect_select
    import rob_cfg_pkg::*, rob_result_pkg::*;
#(
    parameter int  DEPTH = 16,
    localparam int IDX_W = idx_bits(DEPTH)
)(
    input  logic             head_exc,
    input  pc_t              head_pc,
    input  exc_info_t        head_info,
    input  logic [IDX_W-1:0] head_tag,
    input  logic             miss_valid,
    input  logic [IDX_W-1:0] miss_tag,
    input  pc_t              miss_target,
    input  pc_t              trap_vec,
    output logic             redirect_valid,
    output pc_t              redirect_pc,
    output pc_t              epc,
    output cause_t           cause,
    output pc_t              tval,
    output logic             flush_valid,
    output logic             flush_keep_valid,
    output logic [IDX_W-1:0] flush_keep_tag
);

    logic take_trap;  // head exception wins over any branch
    logic take_miss;

    assign take_trap = head_exc;
    assign take_miss = miss_valid && !head_exc;

    // front end target
    always_comb begin
        redirect_valid = take_trap || take_miss;
        redirect_pc    = '0;
        if (take_trap) begin
            redirect_pc = trap_vec;
        end else if (take_miss) begin
            redirect_pc = {miss_target[PC_W-1:1], 1'b0};  // keep fetch aligned
        end
    end

    // trap report, quiet unless a trap is taken
    always_comb begin
        epc   = '0;
        cause = cause_t'(0);
        tval  = '0;
        if (take_trap) begin
            epc   = head_pc;
            cause = head_info.cause;
            tval  = head_info.tval;
        end
    end

    // single flush request for the entry table and the tracker
    always_comb begin
        flush_valid      = take_trap || take_miss;
        flush_keep_valid = 1'b0;
        flush_keep_tag   = '0;
        if (take_trap) begin
            flush_keep_tag = head_tag - IDX_W'(1);  // nothing at or after head survives
        end else if (take_miss) begin
            flush_keep_valid = 1'b1;
            flush_keep_tag   = miss_tag;            // branch and older stay
        end
    end

endmodule

// File: rob_commit_top.sv
// reorder buffer commit stage top level joining entry table, miss tracker and redirect select
`timescale 1ns/1ps

module rob_commit_top
    import rob_cfg_pkg::*, rob_result_pkg::*;
#(
    parameter int  DEPTH = 16,
    parameter int  DEC_W = 2,
    parameter int  EXE_W = 2,
    parameter int  COM_W = 2,
    localparam int IDX_W = idx_bits(DEPTH),
    localparam int CNT_W = cnt_bits(DEPTH)
)(
    input  logic                             clk,
    input  logic                             rst,
    input  logic      [DEC_W-1:0]            dec_valid,
    input  pc_t       [DEC_W-1:0]            dec_pc,
    input  logic      [EXE_W-1:0]            exe_valid,
    input  logic      [EXE_W-1:0][IDX_W-1:0] exe_tag,
    input  logic      [EXE_W-1:0]            exe_misp,
    input  logic      [EXE_W-1:0]            exe_exc,
    input  exe_info_u [EXE_W-1:0]            exe_info,
    input  pc_t                              trap_vec,
    output logic      [IDX_W-1:0]            alloc_tag,
    output logic      [COM_W-1:0]            commit_valid,
    output pc_t       [COM_W-1:0]            commit_pc,
    output logic      [CNT_W-1:0]            credit_ret,
    output logic                             redirect_valid,
    output pc_t                              redirect_pc,
    output pc_t                              epc,
    output cause_t                           cause,
    output pc_t                              tval
);

    logic [IDX_W-1:0] head_tag;
    logic [CNT_W-1:0] occupancy;
    logic             head_exc;
    pc_t              head_pc;
    exc_info_t        head_info;
    logic             miss_valid;
    logic [IDX_W-1:0] miss_tag;
    pc_t              miss_target;
    logic             flush_valid;
    logic             flush_keep_valid;
    logic [IDX_W-1:0] flush_keep_tag;

    rob_entry_table #(
        .DEPTH(DEPTH),
        .DEC_W(DEC_W),
        .COM_W(COM_W),
        .EXE_W(EXE_W)
    ) rob_entry_table_inst (
        .clk              (clk),
        .rst              (rst),
        .dec_valid        (dec_valid),
        .dec_pc           (dec_pc),
        .exe_valid        (exe_valid),
        .exe_tag          (exe_tag),
        .exe_exc          (exe_exc),
        .exe_info         (exe_info),
        .flush_valid      (flush_valid),
        .flush_keep_valid (flush_keep_valid),
        .flush_keep_tag   (flush_keep_tag),
        .alloc_tag        (alloc_tag),
        .head_tag         (head_tag),
        .occupancy        (occupancy),
        .head_exc         (head_exc),
        .head_pc          (head_pc),
        .head_info        (head_info),
        .commit_valid     (commit_valid),
        .commit_pc        (commit_pc),
        .credit_ret       (credit_ret)
    );

    branch_miss_tracker #(
        .DEPTH(DEPTH),
        .EXE_W(EXE_W)
    ) branch_miss_tracker_inst (
        .clk              (clk),
        .rst              (rst),
        .exe_valid        (exe_valid),
        .exe_tag          (exe_tag),
        .exe_misp         (exe_misp),
        .exe_info         (exe_info),
        .head_tag         (head_tag),
        .occupancy        (occupancy),
        .flush_valid      (flush_valid),
        .flush_keep_valid (flush_keep_valid),
        .flush_keep_tag   (flush_keep_tag),
        .miss_valid       (miss_valid),
        .miss_tag         (miss_tag),
        .miss_target      (miss_target)
    );

    redirect_select #(
        .DEPTH(DEPTH)
    ) redirect_select_inst (
        .head_exc         (head_exc),
        .head_pc          (head_pc),
        .head_info        (head_info),
        .head_tag         (head_tag),
        .miss_valid       (miss_valid),
        .miss_tag         (miss_tag),
        .miss_target      (miss_target),
        .trap_vec         (trap_vec),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .epc              (epc),
        .cause            (cause),
        .tval             (tval),
        .flush_valid      (flush_valid),
        .flush_keep_valid (flush_keep_valid),
        .flush_keep_tag   (flush_keep_tag)
    );

endmodule

// File: rob_commit_checker.sv
// protocol assertions on the reorder buffer commit outputs, bound into the top level
`timescale 1ns/1ps

module rob_commit_checker
    import rob_cfg_pkg::*;
#(
    parameter int  DEPTH = 16,
    parameter int  COM_W = 2,
    localparam int CNT_W = cnt_bits(DEPTH)
)(
    input logic             clk,
    input logic             rst,
    input logic [COM_W-1:0] commit_valid,
    input logic [CNT_W-1:0] credit_ret,
    input logic             redirect_valid,
    input logic             head_exc
);

    int fail_count = 0;

    // valid bits form one run starting at slot 0
    a_commit_contiguous: assert property (@(posedge clk) disable iff (rst)
        ((commit_valid + COM_W'(1)) & commit_valid) == '0)
        else begin
            fail_count++;
            $error("commit_valid has a gap: %b", commit_valid);
        end

    a_no_commit_on_trap: assert property (@(posedge clk) disable iff (rst)
        (redirect_valid && head_exc) |-> commit_valid == '0)
        else begin
            fail_count++;
            $error("commit during a trap redirect");
        end

    a_credit_bound: assert property (@(posedge clk) disable iff (rst)
        credit_ret <= CNT_W'(DEPTH))
        else begin
            fail_count++;
            $error("credit_ret %0d exceeds the entry count", credit_ret);
        end

    a_quiet_after_reset: assert property (@(posedge clk)
        ($past(rst) && !rst) |-> (commit_valid == '0 && !redirect_valid && credit_ret == '0))
        else begin
            fail_count++;
            $error("outputs active in the first cycle after reset");
        end

endmodule

bind rob_commit_top rob_commit_checker #(
    .DEPTH(DEPTH),
    .COM_W(COM_W)
) rob_commit_checker_inst (
    .clk           (clk),
    .rst           (rst),
    .commit_valid  (commit_valid),
    .credit_ret    (credit_ret),
    .redirect_valid(redirect_valid),
    .head_exc      (head_exc)
);

// File: tb_clock_gen.sv
// testbench clock and synchronous reset source
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 2,
    parameter int RST_CYCLES  = 3
)(
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // released just after the last reset edge
    end

endmodule

// File: tb_rob_commit.sv
// trace driven testbench for the reorder buffer commit stage, credit model, watchdog and result
`timescale 1ns/1ps

module tb_rob_commit
    import rob_cfg_pkg::*, rob_result_pkg::*;
();

    localparam int  DEPTH           = 16;
    localparam int  DEC_W           = 2;
    localparam int  EXE_W           = 2;
    localparam int  COM_W           = 2;
    localparam int  IDX_W           = idx_bits(DEPTH);
    localparam int  CNT_W           = cnt_bits(DEPTH);
    localparam int  CLK_PERIOD      = 4;
    localparam int  WATCHDOG_MARGIN = 200;
    localparam pc_t TRAP_VEC        = 32'h0000_0100;

    logic                             clk;
    logic                             rst;
    logic      [DEC_W-1:0]            dec_valid;
    pc_t       [DEC_W-1:0]            dec_pc;
    logic      [EXE_W-1:0]            exe_valid;
    logic      [EXE_W-1:0][IDX_W-1:0] exe_tag;
    logic      [EXE_W-1:0]            exe_misp;
    logic      [EXE_W-1:0]            exe_exc;
    exe_info_u [EXE_W-1:0]            exe_info;
    pc_t                              trap_vec;
    logic      [IDX_W-1:0]            alloc_tag;
    logic      [COM_W-1:0]            commit_valid;
    pc_t       [COM_W-1:0]            commit_pc;
    logic      [CNT_W-1:0]            credit_ret;
    logic                             redirect_valid;
    pc_t                              redirect_pc;
    pc_t                              epc;
    cause_t                           cause;
    pc_t                              tval;

    int    value_errors;
    int    other_errors;
    int    assert_errors;
    int    credits;        // decode side view of free entries
    int    total_spent;
    int    total_ret;
    int    cycle_no;
    bit    loaded;
    string trace_q[$];

    tb_clock_gen #(
        .HALF_PERIOD(CLK_PERIOD / 2),
        .RST_CYCLES (3)
    ) tb_clock_gen_inst (
        .clk(clk),
        .rst(rst)
    );

    rob_commit_top rob_commit_top_inst (
        .clk           (clk),
        .rst           (rst),
        .dec_valid     (dec_valid),
        .dec_pc        (dec_pc),
        .exe_valid     (exe_valid),
        .exe_tag       (exe_tag),
        .exe_misp      (exe_misp),
        .exe_exc       (exe_exc),
        .exe_info      (exe_info),
        .trap_vec      (trap_vec),
        .alloc_tag     (alloc_tag),
        .commit_valid  (commit_valid),
        .commit_pc     (commit_pc),
        .credit_ret    (credit_ret),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .epc           (epc),
        .cause         (cause),
        .tval          (tval)
    );

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] cycle %0d %s got %h expected %h", cycle_no, name, got, exp);
        end
    endtask

    task automatic check_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] cycle %0d %s got %h expected %h", cycle_no, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input logic [CNT_W-1:0] got,
                              input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[FAIL] cycle %0d %s got %h expected %h", cycle_no, name, got, exp);
        end
    endtask

    // one trace line is one clock cycle of inputs and expected outputs
    task automatic run_line(input string line);
        logic [DEC_W-1:0]   dv;
        pc_t                pc0, pc1;
        logic [EXE_W-1:0]   ev, mp, ex;
        logic [IDX_W-1:0]   t0, t1;
        logic [INFO_W-1:0]  info0, info1;
        logic [CNT_W-1:0]   exp_cv, exp_cr, exp_rv, exp_at;
        pc_t                exp_cp0, exp_cp1, exp_rpc, exp_epc, exp_tval;
        logic [CAUSE_W-1:0] exp_cause;
        int                 n;
        int                 spent;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    dv, pc0, pc1, ev, t0, t1, mp, ex, info0, info1,
                    exp_cv, exp_cp0, exp_cp1, exp_cr, exp_rv, exp_rpc, exp_epc, exp_cause,
                    exp_tval, exp_at);
        @(posedge clk);
        #1;
        cycle_no++;
        if (n != 20) begin
            other_errors++;
            $display("trace cycle %0d has %0d fields instead of 20 and was skipped", cycle_no, n);
            dec_valid = '0;
            exe_valid = '0;
        end else begin
            dec_valid   = dv;
            dec_pc[0]   = pc0;
            dec_pc[1]   = pc1;
            exe_valid   = ev;
            exe_tag[0]  = t0;
            exe_tag[1]  = t1;
            exe_misp    = mp;
            exe_exc     = ex;
            exe_info[0] = info0;
            exe_info[1] = info1;
            spent = $countones(dv);
            if (spent > credits) begin
                other_errors++;
                $display("trace cycle %0d offers %0d decode slots but only %0d credits are left",
                         cycle_no, spent, credits);
            end
            #2;  // outputs settled, next edge still ahead
            check_mask("alloc_tag", CNT_W'(alloc_tag), exp_at);
            check_mask("commit_valid", CNT_W'(commit_valid), exp_cv);
            check_pc("commit_pc[0]", commit_pc[0], exp_cp0);
            check_pc("commit_pc[1]", commit_pc[1], exp_cp1);
            check_mask("credit_ret", credit_ret, exp_cr);
            check_mask("redirect_valid", CNT_W'(redirect_valid), exp_rv);
            check_pc("redirect_pc", redirect_pc, exp_rpc);
            check_pc("epc", epc, exp_epc);
            check_cause("cause", cause, cause_t'(exp_cause));
            check_pc("tval", tval, exp_tval);
            credits     = credits - spent + int'(credit_ret);
            total_spent = total_spent + spent;
            total_ret   = total_ret + int'(credit_ret);
        end
    endtask

    initial begin
        int    fd;
        string line;
        dec_valid     = '0;
        dec_pc        = '0;
        exe_valid     = '0;
        exe_tag       = '0;
        exe_misp      = '0;
        exe_exc       = '0;
        exe_info      = '0;
        trap_vec      = TRAP_VEC;
        value_errors  = 0;
        other_errors  = 0;
        assert_errors = 0;
        credits       = DEPTH;
        total_spent   = 0;
        total_ret     = 0;
        cycle_no      = 0;
        loaded        = 1'b0;
        fd = $fopen("rob_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open rob_trace.txt for reading");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    trace_q.push_back(line);
                end
            end
            $fclose(fd);
        end
        if (trace_q.size() == 0) begin
            other_errors++;
            $display("the trace holds no cycles to run");
        end
        loaded = 1'b1;
        wait (rst == 1'b0);
        foreach (trace_q[i]) begin
            run_line(trace_q[i]);
        end
        if (total_ret != total_spent) begin
            other_errors++;
            $display("%0d credits came back for %0d allocated slots", total_ret, total_spent);
        end
        assert_errors = rob_commit_top_inst.rob_commit_checker_inst.fail_count;
        $display("%0d value errors, %0d other errors, %0d assertion errors over %0d cycles",
                 value_errors, other_errors, assert_errors, cycle_no);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // run length follows the trace length
    initial begin
        wait (loaded);
        #(trace_q.size() * CLK_PERIOD + WATCHDOG_MARGIN);
        $display("watchdog expired before the trace finished");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: rob_trace.txt
# dv pc0 pc1 ev tag0 tag1 misp exc info0 info1 (inputs, hex)
# commit_valid cpc0 cpc1 credit_ret redir redir_pc epc cause tval alloc_tag (expected, hex)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1000 1004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1008 100c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2
0 0 0 3 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 4
0 0 0 3 2 3 0 0 0 0 3 1000 1004 2 0 0 0 0 0 4
0 0 0 0 0 0 0 0 0 0 3 1008 100c 2 0 0 0 0 0 4
3 2000 2004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4
3 2008 200c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6
0 0 0 3 7 6 0 0 0 0 0 0 0 0 0 0 0 0 0 8
0 0 0 1 5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8
0 0 0 1 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8
0 0 0 0 0 0 0 0 0 0 3 2000 2004 2 0 0 0 0 0 8
0 0 0 0 0 0 0 0 0 0 3 2008 200c 2 0 0 0 0 0 8
3 3000 3004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8
1 3008 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a
0 0 0 3 8 9 0 1 0d00004000 0 0 0 0 0 0 0 0 0 0 b
0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 100 3000 d 4000 b
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8
3 4000 4004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 8
3 4008 400c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a
0 0 0 3 a 9 3 0 5001 6003 0 0 0 0 0 0 0 0 0 c
0 0 0 0 0 0 0 0 0 0 0 0 0 2 1 6002 0 0 0 c
0 0 0 1 8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a
0 0 0 0 0 0 0 0 0 0 3 4000 4004 2 0 0 0 0 0 a
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 a

// File: list.f
rob_cfg_pkg.sv
rob_result_pkg.sv
rob_entry_table.sv
branch_miss_tracker.sv
redirect_select.sv
rob_commit_top.sv
rob_commit_checker.sv
tb_clock_gen.sv
tb_rob_commit.sv

// File: run.sh
#!/usr/bin/env bash
# build the reorder buffer commit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rob_commit \
    -f list.f \
    -o sim_rob_commit

out="$(./obj_dir/sim_rob_commit)"
echo "$out"

if grep -q "TEST RESULT: PASS" <<< "$out"; then
    exit 0
fi
exit 1
